/* logic/fir_arith_pkg.sv */
// FIR arithmetic widths
// Word sizes for each datapath stage and the product scale shift
package fir_arith_pkg;

	// Input and output sample width
	localparam int SAMPLE_W = 18;

	// Fold of two samples needs one extra bit
	localparam int PRESUM_W = SAMPLE_W + 1;

	// Product width after scaling
	localparam int PROD_W = 20;

	// Adder tree width, headroom for five products
	localparam int ACC_W = 23;

	// Normalization of raw coefficient products
	localparam int SCALE_SHIFT = 17;

	// *********************************************************
	// Datapath word types
	// *********************************************************
	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [PRESUM_W-1:0] presum_t;
	typedef logic signed [PROD_W-1:0]   prod_t;
	typedef logic signed [ACC_W-1:0]    acc_t;

endpackage

/* logic/fir_coeff_pkg.sv */
// FIR coefficient set
// Tap counts, symmetric coefficient table and pipeline depth
package fir_coeff_pkg;

	// Full filter length
	localparam int NUM_TAPS = 10;

	// Unique coefficients of a symmetric filter
	localparam int NUM_UNIQ = NUM_TAPS / 2;

	// Coefficient word
	localparam int COEFF_W = 18;

	typedef logic signed [COEFF_W-1:0] coeff_t;

	// *********************************************************
	// Coefficient table
	// *********************************************************
	// Entry k weights the fold of tap k with tap NUM_TAPS-1-k
	// Outer taps first, centre pair last
	localparam coeff_t COEFF [NUM_UNIQ] = '{
		18'sd88,
		18'sd0,
		-18'sd97,
		-18'sd197,
		-18'sd294
	};

	// *********************************************************
	// Pipeline depth
	// *********************************************************
	// Tap line, pre-add, multiply, three tree levels, output reg
	localparam int PIPE_LATENCY = 7;

endpackage

/* logic/fir_tap_line.sv */
// FIR tap delay line
// Shifts in one sample per enabled edge, all ten taps visible
`timescale 1ns/1ps

module fir_tap_line (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_clk_ena,
	input  fir_arith_pkg::sample_t i_sample,
	output fir_arith_pkg::sample_t o_taps [fir_coeff_pkg::NUM_TAPS]
);
	import fir_arith_pkg::*;
	import fir_coeff_pkg::*;

	// *********************************************************
	// Shift register
	// *********************************************************
	// Tap 0 holds the newest sample
	// Invalid samples shift in too, the valid flag runs alongside
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			// Zero history after reset
			for (int i = 0; i < NUM_TAPS; i++) begin
				o_taps[i] <= '0;
			end
		end else if (i_clk_ena) begin
			o_taps[0] <= i_sample;
			// Older samples move one tap down the line
			for (int i = 1; i < NUM_TAPS; i++) begin
				o_taps[i] <= o_taps[i-1];
			end
		end
	end

endmodule

/* logic/fir_preadd.sv */
// FIR symmetric pre-adder
// Folds tap k with its mirror tap, one registered sum per coefficient
`timescale 1ns/1ps

module fir_preadd (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   i_clk_ena,
	input  fir_arith_pkg::sample_t i_taps [fir_coeff_pkg::NUM_TAPS],
	output fir_arith_pkg::presum_t o_sums [fir_coeff_pkg::NUM_UNIQ]
);
	import fir_arith_pkg::*;
	import fir_coeff_pkg::*;

	// Combinational folds before the register
	presum_t fold [NUM_UNIQ];

	// Sign extend both taps so the sum cannot wrap
	always_comb begin
		for (int k = 0; k < NUM_UNIQ; k++) begin
			fold[k] = presum_t'(i_taps[k]) + presum_t'(i_taps[NUM_TAPS-1-k]);
		end
	end

	// *********************************************************
	// Pre-sum register
	// *********************************************************
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int k = 0; k < NUM_UNIQ; k++) begin
				o_sums[k] <= '0;
			end
		end else if (i_clk_ena) begin
			o_sums <= fold;
		end
	end

endmodule

/* logic/fir_mult_stage.sv */
// FIR coefficient multipliers
// Weights each pre-sum by its coefficient and scales the product down
`timescale 1ns/1ps

module fir_mult_stage (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   i_clk_ena,
	input  fir_arith_pkg::presum_t i_sums  [fir_coeff_pkg::NUM_UNIQ],
	output fir_arith_pkg::prod_t   o_prods [fir_coeff_pkg::NUM_UNIQ]
);
	import fir_arith_pkg::*;
	import fir_coeff_pkg::*;

	// Full precision product word
	typedef logic signed [PRESUM_W+COEFF_W-1:0] raw_t;

	raw_t raw    [NUM_UNIQ];
	raw_t scaled [NUM_UNIQ];

	// *********************************************************
	// Multiply and scale
	// *********************************************************
	always_comb begin
		for (int k = 0; k < NUM_UNIQ; k++) begin
			// Both operands widened first, keeps the multiply signed
			raw[k] = raw_t'(i_sums[k]) * raw_t'(COEFF[k]);
			// Arithmetic shift keeps the sign of negative products
			scaled[k] = raw[k] >>> SCALE_SHIFT;
		end
	end

	// Scaled value always fits PROD_W bits
	// Coefficient magnitudes are small against 2^17
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int k = 0; k < NUM_UNIQ; k++) begin
				o_prods[k] <= '0;
			end
		end else if (i_clk_ena) begin
			for (int k = 0; k < NUM_UNIQ; k++) begin
				o_prods[k] <= scaled[k][PROD_W-1:0];
			end
		end
	end

endmodule

/* logic/fir_adder_tree.sv */
// FIR adder tree
// Three registered levels sum the five scaled products
`timescale 1ns/1ps

module fir_adder_tree (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_clk_ena,
	input  fir_arith_pkg::prod_t i_prods [fir_coeff_pkg::NUM_UNIQ],
	output fir_arith_pkg::acc_t  o_acc
);
	import fir_arith_pkg::*;
	import fir_coeff_pkg::*;

	// Products widened to tree precision
	acc_t prod_ext [NUM_UNIQ];

	// Level 1 partial sums and bypass
	acc_t l1_sum_a;
	acc_t l1_sum_b;
	acc_t l1_byp;

	// Level 2 sum and bypass
	acc_t l2_sum;
	acc_t l2_byp;

	always_comb begin
		for (int k = 0; k < NUM_UNIQ; k++) begin
			prod_ext[k] = acc_t'(i_prods[k]);
		end
	end

	// *********************************************************
	// Level 1
	// *********************************************************
	// Pairs 0+1 and 2+3, product 4 has no partner
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			l1_sum_a <= '0;
			l1_sum_b <= '0;
			l1_byp   <= '0;
		end else if (i_clk_ena) begin
			l1_sum_a <= prod_ext[0] + prod_ext[1];
			l1_sum_b <= prod_ext[2] + prod_ext[3];
			l1_byp   <= prod_ext[4];
		end
	end

	// *********************************************************
	// Level 2
	// *********************************************************
	// Odd operand rides the bypass for one more level
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			l2_sum <= '0;
			l2_byp <= '0;
		end else if (i_clk_ena) begin
			l2_sum <= l1_sum_a + l1_sum_b;
			l2_byp <= l1_byp;
		end
	end

	// *********************************************************
	// Level 3
	// *********************************************************
	// Final sum of all five weighted folds
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_acc <= '0;
		end else if (i_clk_ena) begin
			o_acc <= l2_sum + l2_byp;
		end
	end

endmodule

/* logic/fir_valid_align.sv */
// FIR valid alignment
// Delays the input valid flag by the full datapath depth
`timescale 1ns/1ps

module fir_valid_align (
	input  logic clk,
	input  logic reset,
	input  logic i_clk_ena,
	input  logic i_valid,
	output logic o_valid
);
	import fir_coeff_pkg::*;

	// One flag per pipeline stage
	logic [PIPE_LATENCY-1:0] vld_sr;

	// Advances only when the datapath does
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			vld_sr <= '0;
		end else if (i_clk_ena) begin
			vld_sr <= {vld_sr[PIPE_LATENCY-2:0], i_valid};
		end
	end

	// Oldest flag qualifies the output register
	assign o_valid = vld_sr[PIPE_LATENCY-1];

endmodule

/* logic/fir_top.sv */
// Symmetric 10-tap FIR filter
// Tap line, pre-adders, multipliers and adder tree with a global stall
`timescale 1ns/1ps

module fir_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   i_clk_ena,
	input  logic                   i_valid,
	input  fir_arith_pkg::sample_t i_sample,
	output logic                   o_valid,
	output fir_arith_pkg::sample_t o_sample
);
	import fir_arith_pkg::*;
	import fir_coeff_pkg::*;

	// Stage to stage wires
	sample_t taps  [NUM_TAPS];
	presum_t sums  [NUM_UNIQ];
	prod_t   prods [NUM_UNIQ];
	acc_t    acc;

	// *********************************************************
	// Datapath
	// *********************************************************
	fir_tap_line u_tap_line (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_sample  (i_sample),
		.o_taps    (taps)
	);

	fir_preadd u_preadd (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_taps    (taps),
		.o_sums    (sums)
	);

	fir_mult_stage u_mult_stage (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_sums    (sums),
		.o_prods   (prods)
	);

	fir_adder_tree u_adder_tree (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_prods   (prods),
		.o_acc     (acc)
	);

	// Valid flag runs beside the data
	fir_valid_align u_valid_align (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.o_valid   (o_valid)
	);

	// *********************************************************
	// Output register
	// *********************************************************
	// Plain truncation, the scaled sum always fits the sample width
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_sample <= '0;
		end else if (i_clk_ena) begin
			o_sample <= acc[SAMPLE_W-1:0];
		end
	end

endmodule

/* testbench/fir_checker.sv */
// FIR output checker
// Concurrent assertions on the filter's top-level ports
`timescale 1ns/1ps

module fir_checker (
	input logic                   clk,
	input logic                   reset,
	input logic                   i_clk_ena,
	input logic                   i_out_valid,
	input fir_arith_pkg::sample_t i_out_sample
);

	// *********************************************************
	// Reset
	// *********************************************************
	// No qualified output while reset is held
	a_reset_quiet: assert property (
		@(posedge clk) reset |-> !i_out_valid
	) else $error("o_valid high while reset is asserted");

	// *********************************************************
	// Stall
	// *********************************************************
	// Whole pipeline frozen, outputs keep their last value
	a_stall_hold: assert property (
		@(posedge clk) disable iff (reset)
		!i_clk_ena |=> ($stable(i_out_sample) && $stable(i_out_valid))
	) else $error("Outputs changed while the clock enable was low");

	// Flag must always be a clean level
	a_valid_known: assert property (
		@(posedge clk) !$isunknown(i_out_valid)
	) else $error("o_valid is unknown");

endmodule

/* testbench/fir_tb.sv */
// FIR filter testbench
// Replays a stimulus trace and checks outputs in order under a watchdog
`timescale 1ns/1ps

module fir_tb;
	import fir_arith_pkg::*;
	import fir_coeff_pkg::*;

	// Trace location and timing
	localparam string TRACE_FILE   = "testbench/fir_trace.txt";
	localparam int    CLK_PERIOD   = 8;
	localparam int    RESET_CYCLES = 5;
	// Enough enabled edges to drain every sample in flight
	localparam int    FLUSH_CYCLES = PIPE_LATENCY + 2;
	// Slack on top of trace and pipeline depth
	localparam int    WD_MARGIN    = 20;

	logic    clk;
	logic    reset;
	logic    i_clk_ena;
	logic    i_valid;
	sample_t i_sample;
	logic    o_valid;
	sample_t o_sample;

	// Stimulus with one entry per clock
	logic    stim_ena [$];
	logic    stim_vld [$];
	sample_t stim_smp [$];
	// Expected outputs in arrival order
	sample_t exp_smp  [$];
	// Valid flags captured on enabled edges
	logic    vld_hist [$];

	int      stim_total;
	int      exp_total;
	int      out_count;
	bit      trace_loaded;

	fir_top i_fir_top (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_sample  (i_sample),
		.o_valid   (o_valid),
		.o_sample  (o_sample)
	);

	bind fir_top fir_checker i_fir_checker (
		.clk          (clk),
		.reset        (reset),
		.i_clk_ena    (i_clk_ena),
		.i_out_valid  (o_valid),
		.i_out_sample (o_sample)
	);

	// *********************************************************
	// Reporting
	// *********************************************************
	task automatic abort_run(string reason);
		$display("%s", reason);
		$display("sim failed");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic compare_sample(string name, sample_t got, sample_t exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL at %0t ns: %s got %0d expected %0d",
				$time, name, got, exp));
		end
	endtask

	task automatic compare_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL at %0t ns: %s got %b expected %b",
				$time, name, got, exp));
		end
	endtask

	function automatic bit is_blank(int ch);
		return ch == int'(" ") || ch == int'("\t") ||
			ch == int'("\n") || ch == int'("\r");
	endfunction

	// *********************************************************
	// Trace reader
	// *********************************************************
	// S lines hold stimulus and E lines hold expected values
	// A # starts a comment line
	task automatic load_trace();
		int fd;
		int ch;
		int code;
		int cnt;
		int ena;
		int vld;
		int val;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			abort_run($sformatf("Could not open trace file %s", TRACE_FILE));
		end
		ch = $fgetc(fd);
		while (ch != -1) begin
			if (ch == int'("#")) begin
				// Skip to end of line
				while (ch != -1 && ch != int'("\n")) begin
					ch = $fgetc(fd);
				end
			end else if (ch == int'("S")) begin
				code = $fscanf(fd, "%d %d %d", ena, vld, cnt);
				if (code != 3) begin
					abort_run("Malformed stimulus line in the trace");
				end
				for (int i = 0; i < cnt; i++) begin
					code = $fscanf(fd, "%d", val);
					if (code != 1) begin
						abort_run("A stimulus line in the trace is short of samples");
					end
					stim_ena.push_back(ena != 0);
					stim_vld.push_back(vld != 0);
					stim_smp.push_back(sample_t'(val));
				end
			end else if (ch == int'("E")) begin
				code = $fscanf(fd, "%d", cnt);
				if (code != 1) begin
					abort_run("Malformed expected-output line in the trace");
				end
				for (int i = 0; i < cnt; i++) begin
					code = $fscanf(fd, "%d", val);
					if (code != 1) begin
						abort_run("An expected-output line in the trace is short of values");
					end
					exp_smp.push_back(sample_t'(val));
				end
			end else if (!is_blank(ch)) begin
				abort_run($sformatf("Unexpected character code %0d in the trace", ch));
			end
			ch = $fgetc(fd);
		end
		$fclose(fd);
	endtask

	// *********************************************************
	// Output tracking
	// *********************************************************
	// Runs on enabled edges and sees the outputs from before the edge
	task automatic track_output();
		logic exp_vld;
		// Flag now belongs to the sample captured PIPE_LATENCY enabled edges ago
		if (vld_hist.size() >= PIPE_LATENCY) begin
			exp_vld = vld_hist.pop_front();
		end else begin
			exp_vld = 1'b0;
		end
		compare_flag("o_valid", o_valid, exp_vld);
		if (o_valid === 1'b1) begin
			if (exp_smp.size() == 0) begin
				abort_run("The DUT produced more outputs than the trace expects");
			end else begin
				compare_sample("o_sample", o_sample, exp_smp.pop_front());
				out_count++;
			end
		end
		vld_hist.push_back(i_valid);
	endtask

	always @(posedge clk) begin
		if (!reset && i_clk_ena) begin
			track_output();
		end
	end

	// *********************************************************
	// Clock, stimulus, watchdog
	// *********************************************************
	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	initial begin
		// Inputs stay busy during reset and must not reach the pipeline
		reset     = 1'b1;
		i_clk_ena = 1'b1;
		i_valid   = 1'b1;
		i_sample  = sample_t'(-131072);
		out_count = 0;
		load_trace();
		stim_total   = stim_ena.size();
		exp_total    = exp_smp.size();
		trace_loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset     <= 1'b0;
		i_clk_ena <= 1'b0;
		i_valid   <= 1'b0;
		i_sample  <= '0;
		while (stim_ena.size() > 0) begin
			@(posedge clk);
			i_clk_ena <= stim_ena.pop_front();
			i_valid   <= stim_vld.pop_front();
			i_sample  <= stim_smp.pop_front();
		end
		// Drain with invalid zeros
		repeat (FLUSH_CYCLES) begin
			@(posedge clk);
			i_clk_ena <= 1'b1;
			i_valid   <= 1'b0;
			i_sample  <= '0;
		end
		@(negedge clk);
		if (exp_smp.size() != 0) begin
			abort_run($sformatf("Only %0d of %0d expected outputs arrived",
				out_count, exp_total));
		end else begin
			$display("sim passed");
			$finish;
		end
	end

	initial begin
		wait (trace_loaded);
		#((stim_total + PIPE_LATENCY + WD_MARGIN) * CLK_PERIOD);
		abort_run($sformatf("Watchdog expired, outputs stopped arriving after %0d of %0d",
			out_count, exp_total));
	end

endmodule

/* testbench/fir_trace.txt */
# FIR filter trace, one sample per clock
# S ena valid count sample... : clock enable, valid flag, number of samples, samples
# E count value... : expected o_sample values in output order
# Impulse of -131072 into zero history
S 1 1 1 -131072
S 1 1 9 0 0 0 0 0 0 0 0 0
E 10 -88 0 97 197 294 294 197 97 0 -88
# Steady stream, multiples of 16384
S 1 1 4 81920 -49152 114688 -98304
# Stall mid-stream, samples shown while disabled are never captured
S 0 1 4 12345 -54321 99999 -7
S 1 1 4 32768 -131072 65536 -16384
E 8 55 -33 16 -154 -174 -263 -104 12
# Valid gaps, invalid samples still fill the taps
S 1 0 1 49152
S 1 1 1 -32768
# Stall with a valid output held on the port
S 0 1 3 1 2 3
S 1 0 1 98304
S 1 1 1 16384
E 2 229 100

/* verilog.f */
logic/fir_arith_pkg.sv
logic/fir_coeff_pkg.sv
logic/fir_tap_line.sv
logic/fir_preadd.sv
logic/fir_mult_stage.sv
logic/fir_adder_tree.sv
logic/fir_valid_align.sv
logic/fir_top.sv
testbench/fir_checker.sv
testbench/fir_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the FIR filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module fir_tb -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vfir_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
	echo "Testbench reported a failure"
	exit 1
fi

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

echo "Simulation finished cleanly"
exit 0
